/* list.f */
+incdir+src
src/ahbl_bridge_pkg.sv
src/axi_resp_if.sv
src/txn_if.sv
src/ahb_txn_detect.sv
src/burst_tracker.sv
src/hready_ctrl.sv
src/resp_mux.sv
src/ahbl_ctrl_top.sv
testbench/tb_ahbl_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the AHB-Lite control testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_ahbl_ctrl \
  -o tb_ahbl_ctrl_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_ahbl_ctrl_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

/* testbench/tb_ahbl_ctrl.sv */
module tb_ahbl_ctrl;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NROWS = 11;

  logic                       ACLK;
  logic                       sysReset;
  logic                       hsel;
  ahbl_bridge_pkg::htrans_t   htrans;
  logic                       hwrite;
  ahbl_bridge_pkg::hburst_t   hburst;
  logic                       bvalid;
  logic                       bready;
  ahbl_bridge_pkg::axi_resp_t bresp;
  logic                       rvalid;
  logic                       rready;
  logic                       rlast;
  ahbl_bridge_pkg::axi_resp_t rresp;
  ahbl_bridge_pkg::data_t     rdata;
  logic                       wready;
  logic                       wlast;
  ahbl_bridge_pkg::data_t     hrdata;
  logic                       hresp;
  logic                       hready;
  logic                       ahb_write_req;
  logic                       ahb_read_req;
  logic                       valid_ahb_wrdata;

  // Scenario rows give direction, burst type, response code and maximum stall per beat.
  bit                         row_write [NROWS] = '{1, 0, 1, 0, 1, 0, 1, 0, 1, 0, 1};
  ahbl_bridge_pkg::hburst_t   row_burst [NROWS] = '{ahbl_bridge_pkg::SINGLE,
    ahbl_bridge_pkg::SINGLE, ahbl_bridge_pkg::INCR4, ahbl_bridge_pkg::WRAP4,
    ahbl_bridge_pkg::WRAP8, ahbl_bridge_pkg::INCR8, ahbl_bridge_pkg::INCR16,
    ahbl_bridge_pkg::WRAP16, ahbl_bridge_pkg::SINGLE, ahbl_bridge_pkg::SINGLE,
    ahbl_bridge_pkg::INCR4};
  ahbl_bridge_pkg::axi_resp_t row_resp [NROWS] = '{2'b00, 2'b00, 2'b00, 2'b00, 2'b10,
    2'b00, 2'b00, 2'b11, 2'b11, 2'b10, 2'b00};
  int                         row_stall [NROWS] = '{0, 0, 2, 0, 1, 0, 3, 0, 0, 0, 0};

  int value_errs;
  int proto_errs;
  int cycles;
  int limit;
  ahbl_bridge_pkg::data_t exp_q [$];

  ahbl_ctrl_top DUT (.ACLK(ACLK), .sysReset(sysReset), .hsel(hsel), .htrans(htrans),
    .hwrite(hwrite), .hburst(hburst), .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .rvalid(rvalid), .rready(rready), .rlast(rlast), .rresp(rresp), .rdata(rdata),
    .wready(wready), .wlast(wlast), .hrdata(hrdata), .hresp(hresp), .hready(hready),
    .ahb_write_req(ahb_write_req), .ahb_read_req(ahb_read_req),
    .valid_ahb_wrdata(valid_ahb_wrdata));

  initial
  begin
    ACLK = 1'b0;
    forever #4 ACLK = ~ACLK;
  end

  // Beats of a burst type. INCR counts as a single beat.
  function automatic int burst_beats(input ahbl_bridge_pkg::hburst_t b);
    case (b)
      ahbl_bridge_pkg::WRAP4, ahbl_bridge_pkg::INCR4:   return 4;
      ahbl_bridge_pkg::WRAP8, ahbl_bridge_pkg::INCR8:   return 8;
      ahbl_bridge_pkg::WRAP16, ahbl_bridge_pkg::INCR16: return 16;
      default:                                          return 1;
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("FAIL t=%0t %s got=%0h expected=%0h", $time, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic report_problem(input string msg);
    $display("Error at t=%0t: %s", $time, msg);
    proto_errs++;
  endtask

  task automatic run_row(input int r);
    int beats;
    int addressed;
    int done;
    int sent;
    int stall_left;
    int req_cnt;
    int wr_cnt;
    int wphase;
    int since_comp;
    bit comp_now;
    bit rd_turn;
    bit finished;
    beats      = burst_beats(row_burst[r]);
    addressed  = 0;
    done       = 0;
    sent       = 0;
    stall_left = 0;
    req_cnt    = 0;
    wr_cnt     = 0;
    wphase     = 0;
    since_comp = -1;
    finished   = 1'b0;
    exp_q.delete();
    while (!finished)
    begin
      @(negedge ACLK);
      // Read data is offered while the DUT holds the data phase.
      rd_turn = !row_write[r] && !hready && (addressed > 0) && (sent < beats);
      hburst  = row_burst[r];
      hwrite  = row_write[r];
      if (addressed < beats)
      begin
        hsel   = 1'b1;
        htrans = (addressed == 0) ? ahbl_bridge_pkg::NONSEQ : ahbl_bridge_pkg::SEQ;
      end
      else
      begin
        hsel   = 1'b0;
        htrans = ahbl_bridge_pkg::IDLE;
      end
      wready   = 1'b1;
      wlast    = 1'b0;
      bvalid   = 1'b0;
      bresp    = 2'b00;
      rvalid   = 1'b0;
      rlast    = 1'b0;
      rresp    = 2'b00;
      comp_now = 1'b0;
      if (row_write[r])
      begin
        if ((addressed > 0) && (addressed < beats) && (stall_left > 0))
        begin
          wready = 1'b0;
          stall_left--;
        end
        if (wphase == 1)
        begin
          wlast  = 1'b1;
          wphase = 2;
        end
        else if (wphase == 2)
        begin
          bvalid   = 1'b1;
          bresp    = row_resp[r];
          comp_now = 1'b1;
          wphase   = 3;
        end
      end
      else if (rd_turn)
      begin
        rvalid = 1'b1;
        rdata  = $urandom;
        exp_q.push_back(rdata);
        sent++;
        if (sent == beats)
        begin
          rlast    = 1'b1;
          rresp    = row_resp[r];
          comp_now = 1'b1;
        end
      end
      #3;
      if (since_comp >= 0)
        since_comp++;
      if (comp_now)
        since_comp = 0;
      // ERROR is visible in the completion cycle and the one after.
      if ((since_comp == 0) || (since_comp == 1))
        compare_value("hresp", hresp, row_resp[r][1]);
      else
        compare_value("hresp", hresp, 1'b0);
      if (!wready && hready)
        report_problem("hready high while wready is held low");
      if (ahb_write_req || ahb_read_req)
      begin
        req_cnt++;
        if (htrans != ahbl_bridge_pkg::NONSEQ)
          report_problem("request strobe without a NONSEQ address phase");
        if (ahb_write_req != row_write[r])
          report_problem("request strobe of the wrong direction");
      end
      if (valid_ahb_wrdata)
        wr_cnt++;
      if ((beats == 1) && (addressed > 0) && (since_comp < 1) && hready)
        report_problem("hready high before the single transfer completed");
      if (!row_write[r] && hready && (done < addressed))
      begin
        if (done < exp_q.size())
          compare_value("hrdata", hrdata, exp_q[done]);
        else
          report_problem("read data phase ended before any data arrived");
        done++;
      end
      if (hready && ((htrans == ahbl_bridge_pkg::NONSEQ) ||
                     (htrans == ahbl_bridge_pkg::SEQ)))
      begin
        addressed++;
        if (addressed < beats)
          stall_left = int'($urandom % (row_stall[r] + 1));
        else if (row_write[r])
          wphase = 1;
      end
      if ((since_comp >= 1) && hready)
        finished = 1'b1;
    end
    compare_value("request count", req_cnt, 1);
    compare_value("valid_ahb_wrdata count", wr_cnt, row_write[r] ? beats : 0);
    if (!row_write[r])
      compare_value("read data phases", done, beats);
  endtask

  // The run is bounded by a cycle budget taken from the table.
  always @(posedge ACLK)
  begin
    cycles++;
    if (cycles >= limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial
  begin
    void'($urandom(32'h8cbe));
    value_errs = 0;
    proto_errs = 0;
    cycles     = 0;
    limit      = 200;
    for (int i = 0; i < NROWS; i++)
      limit += burst_beats(row_burst[i]) * (row_stall[i] + 8);
    sysReset = 1'b0;
    hsel     = 1'b0;
    htrans   = ahbl_bridge_pkg::IDLE;
    hwrite   = 1'b0;
    hburst   = ahbl_bridge_pkg::SINGLE;
    bvalid   = 1'b0;
    bready   = 1'b1;
    bresp    = 2'b00;
    rvalid   = 1'b0;
    rready   = 1'b1;
    rlast    = 1'b0;
    rresp    = 2'b00;
    rdata    = '0;
    wready   = 1'b1;
    wlast    = 1'b0;
    repeat (8) @(posedge ACLK);
    @(negedge ACLK);
    sysReset = 1'b1;
    #3;
    compare_value("hready", hready, 1'b1);
    compare_value("hresp", hresp, 1'b0);
    compare_value("ahb_write_req", ahb_write_req, 1'b0);
    compare_value("ahb_read_req", ahb_read_req, 1'b0);
    compare_value("valid_ahb_wrdata", valid_ahb_wrdata, 1'b0);
    compare_value("hrdata", hrdata, 32'h0);
    for (int r = 0; r < NROWS; r++)
      run_row(r);
    $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
    if ((value_errs == 0) && (proto_errs == 0))
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

/* src/ahbl_ctrl_top.sv */
`include "ahbl_bridge_settings.svh"

module ahbl_ctrl_top
(
  input  logic                       ACLK,
  input  logic                       sysReset,
  input  logic                       hsel,
  input  ahbl_bridge_pkg::htrans_t   htrans,
  input  logic                       hwrite,
  input  ahbl_bridge_pkg::hburst_t   hburst,
  input  logic                       bvalid,
  input  logic                       bready,
  input  ahbl_bridge_pkg::axi_resp_t bresp,
  input  logic                       rvalid,
  input  logic                       rready,
  input  logic                       rlast,
  input  ahbl_bridge_pkg::axi_resp_t rresp,
  input  logic [`AHBL_DATA_WIDTH-1:0] rdata,
  input  logic                       wready,
  input  logic                       wlast,
  output ahbl_bridge_pkg::data_t     hrdata,
  output logic                       hresp,
  output logic                       hready,
  output logic                       ahb_write_req,
  output logic                       ahb_read_req,
  output logic                       valid_ahb_wrdata
);

  logic cnt_zero;
  logic cnt_one;
  logic rlast_seen;

  axi_resp_if axi_bus ();
  txn_if      txn_bus ();

  // AXI side return signals into the shared bundle.
  assign axi_bus.bvalid = bvalid;
  assign axi_bus.bready = bready;
  assign axi_bus.bresp  = bresp;
  assign axi_bus.rvalid = rvalid;
  assign axi_bus.rready = rready;
  assign axi_bus.rlast  = rlast;
  assign axi_bus.rresp  = rresp;
  assign axi_bus.rdata  = rdata;
  assign axi_bus.wready = wready;
  assign axi_bus.wlast  = wlast;

  ahb_txn_detect u_detect (.ACLK(ACLK), .sysReset(sysReset), .hsel(hsel), .htrans(htrans),
    .hwrite(hwrite), .hburst(hburst), .hready(hready), .axi(axi_bus.trk),
    .txn(txn_bus.src), .ahb_write_req(ahb_write_req), .ahb_read_req(ahb_read_req));

  burst_tracker u_tracker (.ACLK(ACLK), .sysReset(sysReset), .htrans(htrans),
    .hburst(hburst), .hready(hready), .axi(axi_bus.trk), .txn(txn_bus.dst),
    .cnt_zero(cnt_zero), .cnt_one(cnt_one), .rlast_seen(rlast_seen));

  hready_ctrl u_hready (.ACLK(ACLK), .sysReset(sysReset), .htrans(htrans), .hwrite(hwrite),
    .hburst(hburst), .cnt_zero(cnt_zero), .cnt_one(cnt_one), .rlast_seen(rlast_seen),
    .axi(axi_bus.sink), .txn(txn_bus.dst), .hready(hready),
    .valid_ahb_wrdata(valid_ahb_wrdata));

  resp_mux u_resp (.ACLK(ACLK), .sysReset(sysReset), .axi(axi_bus.sink),
    .txn(txn_bus.dst), .hrdata(hrdata), .hresp(hresp));

endmodule

/* src/resp_mux.sv */
module resp_mux
(
  input  logic                   ACLK,
  input  logic                   sysReset,
  axi_resp_if.sink               axi,
  txn_if.dst                     txn,
  output ahbl_bridge_pkg::data_t hrdata,
  output logic                   hresp
);

  logic read_comp;
  logic wr_err;
  logic rd_last_err;
  logic wr_err_q;
  logic rd_sel_q;
  logic rd_err_seen_q;
  logic rd_err_q;

  assign read_comp   = axi.rvalid & axi.rready & axi.rlast;
  assign wr_err      = axi.bvalid & axi.bready & axi.bresp[1];
  assign rd_last_err = read_comp & axi.rresp[1];

  // Read data register.
  always_ff @(posedge ACLK or negedge sysReset)
  begin
    if (!sysReset)
      hrdata <= '0;
    else if (axi.rvalid)
      hrdata <= axi.rdata;
  end

  always_ff @(posedge ACLK or negedge sysReset)
  begin
    if (!sysReset)
    begin
      wr_err_q      <= 1'b0;
      rd_sel_q      <= 1'b0;
      rd_err_seen_q <= 1'b0;
      rd_err_q      <= 1'b0;
    end
    else
    begin
      wr_err_q <= wr_err;
      rd_sel_q <= txn.read_active;
      // Any erroring beat of the burst is remembered until the read ends.
      if (axi.rvalid && axi.rready && axi.rresp[1])
        rd_err_seen_q <= 1'b1;
      else if (!rd_sel_q)
        rd_err_seen_q <= 1'b0;
      rd_err_q <= read_comp & (axi.rresp[1] | rd_err_seen_q);
    end
  end

  // ERROR is shown in the completion cycle and the one after.
  assign hresp = rd_sel_q ? (rd_last_err | rd_err_q) : (wr_err | wr_err_q);

endmodule

/* src/hready_ctrl.sv */
module hready_ctrl
(
  input  logic                     ACLK,
  input  logic                     sysReset,
  input  ahbl_bridge_pkg::htrans_t htrans,
  input  logic                     hwrite,
  input  ahbl_bridge_pkg::hburst_t hburst,
  input  logic                     cnt_zero,
  input  logic                     cnt_one,
  input  logic                     rlast_seen,
  axi_resp_if.sink                 axi,
  txn_if.dst                       txn,
  output logic                     hready,
  output logic                     valid_ahb_wrdata
);

  logic read_comp;
  logic axi_comp;
  logic fixed_burst;
  logic single_rdy_q;
  logic fix_rdy_q;
  logic fix_rdy_en;
  logic fix_rdy;

  assign read_comp   = axi.rvalid & axi.rready & axi.rlast;
  assign axi_comp    = (axi.bvalid & axi.bready) | read_comp;
  assign fixed_burst = (hburst[2:1] != 2'b00);

  // Single transfers hold HREADY low from acceptance until completion.
  always_ff @(posedge ACLK or negedge sysReset)
  begin
    if (!sysReset)
      single_rdy_q <= 1'b1;
    else if (axi_comp && txn.single)
      single_rdy_q <= 1'b1;
    else if (txn.new_trans && txn.single)
      single_rdy_q <= 1'b0;
  end

  assign fix_rdy_en = fixed_burst | axi_comp | rlast_seen;

  // Fixed bursts stop after the last counted beat and wait for read data.
  always_ff @(posedge ACLK or negedge sysReset)
  begin
    if (!sysReset)
      fix_rdy_q <= 1'b1;
    else if (txn.single && (htrans != ahbl_bridge_pkg::IDLE))
      fix_rdy_q <= 1'b1;
    else if (fix_rdy_en)
    begin
      if (txn.read_det)
        fix_rdy_q <= 1'b0;
      else if (cnt_zero || (txn.read_active && cnt_one && read_comp) || rlast_seen)
        fix_rdy_q <= 1'b1;
      else
        fix_rdy_q <= !(cnt_one && hready) && !(txn.read_active && !axi.rvalid);
    end
  end

  // Write data phases also wait on the AXI write channel.
  assign fix_rdy = txn.write_active ? (fix_rdy_q & axi.wready) : fix_rdy_q;

  assign hready = single_rdy_q & fix_rdy;

  assign valid_ahb_wrdata = hready && hwrite &&
                            ((htrans == ahbl_bridge_pkg::NONSEQ) ||
                             (htrans == ahbl_bridge_pkg::SEQ));

endmodule

/* src/burst_tracker.sv */
module burst_tracker
(
  input  logic                     ACLK,
  input  logic                     sysReset,
  input  ahbl_bridge_pkg::htrans_t htrans,
  input  ahbl_bridge_pkg::hburst_t hburst,
  input  logic                     hready,
  axi_resp_if.trk                  axi,
  txn_if.dst                       txn,
  output logic                     cnt_zero,
  output logic                     cnt_one,
  output logic                     rlast_seen
);

  ahbl_bridge_pkg::burst_cnt_t cnt;
  ahbl_bridge_pkg::burst_cnt_t load_val;
  logic                        beat_acc;
  logic                        reload;

  // Remaining beats after the first, by burst length.
  always_comb
  begin
    case (hburst[2:1])
      2'b10:   load_val = ahbl_bridge_pkg::burst_cnt_t'(7);
      2'b11:   load_val = ahbl_bridge_pkg::burst_cnt_t'(15);
      default: load_val = ahbl_bridge_pkg::burst_cnt_t'(3);
    endcase
  end

  assign beat_acc = hready && ((htrans == ahbl_bridge_pkg::NONSEQ) ||
                               (htrans == ahbl_bridge_pkg::SEQ));

  // Read completion is seen one cycle late.
  always_ff @(posedge ACLK or negedge sysReset)
  begin
    if (!sysReset)
      rlast_seen <= 1'b0;
    else
      rlast_seen <= axi.rvalid & axi.rready & axi.rlast;
  end

  assign reload = txn.new_trans_pulse | (axi.bvalid & axi.bready) | rlast_seen;

  always_ff @(posedge ACLK or negedge sysReset)
  begin
    if (!sysReset)
      cnt <= ahbl_bridge_pkg::burst_cnt_t'(3);
    else if (reload)
      cnt <= load_val;
    else if (beat_acc)
      cnt <= cnt - 1'b1;
  end

  assign cnt_zero = (cnt == '0);
  assign cnt_one  = (cnt == ahbl_bridge_pkg::burst_cnt_t'(1));

endmodule

/* src/ahb_txn_detect.sv */
module ahb_txn_detect
(
  input  logic                     ACLK,
  input  logic                     sysReset,
  input  logic                     hsel,
  input  ahbl_bridge_pkg::htrans_t htrans,
  input  logic                     hwrite,
  input  ahbl_bridge_pkg::hburst_t hburst,
  input  logic                     hready,
  axi_resp_if.trk                  axi,
  txn_if.src                       txn,
  output logic                     ahb_write_req,
  output logic                     ahb_read_req
);

  logic read_comp;
  logic axi_comp;
  logic new_trans_q;
  logic write_active_q;
  logic read_active_q;

  assign read_comp = axi.rvalid & axi.rready & axi.rlast;
  assign axi_comp  = (axi.bvalid & axi.bready) | read_comp;

  // An accepted NONSEQ address phase starts a transfer.
  assign txn.new_trans = hsel & hready & (htrans == ahbl_bridge_pkg::NONSEQ);

  // INCR is paced like SINGLE.
  assign txn.single = (hburst == ahbl_bridge_pkg::SINGLE) ||
                      (hburst == ahbl_bridge_pkg::INCR);

  always_ff @(posedge ACLK or negedge sysReset)
  begin
    if (!sysReset)
      new_trans_q <= 1'b0;
    else if (txn.new_trans)
      new_trans_q <= 1'b1;
    else if (axi_comp)
      new_trans_q <= 1'b0;
  end

  assign txn.new_trans_pulse = txn.new_trans & ~new_trans_q;

  // Requests toward the AXI side are one-cycle strobes.
  assign ahb_write_req = txn.new_trans & hwrite;
  assign ahb_read_req  = txn.new_trans & ~hwrite;
  assign txn.read_det  = ahb_read_req;

  // Write stays active until the last write beat leaves.
  always_ff @(posedge ACLK or negedge sysReset)
  begin
    if (!sysReset)
      write_active_q <= 1'b0;
    else if (ahb_write_req)
      write_active_q <= 1'b1;
    else if (axi.wlast)
      write_active_q <= 1'b0;
  end

  always_ff @(posedge ACLK or negedge sysReset)
  begin
    if (!sysReset)
      read_active_q <= 1'b0;
    else if (ahb_read_req)
      read_active_q <= 1'b1;
    else if (read_comp)
      read_active_q <= 1'b0;
  end

  assign txn.write_active = write_active_q;
  // Read activity covers the request cycle as well.
  assign txn.read_active  = ahb_read_req | read_active_q;

endmodule

/* src/txn_if.sv */
interface txn_if;

  logic new_trans;
  logic new_trans_pulse;
  logic single;
  logic write_active;
  logic read_det;
  logic read_active;

  // Driven by the address phase decoder.
  modport src (output new_trans, new_trans_pulse, single, write_active, read_det,
               output read_active);

  // Read by the pacing logic.
  modport dst (input new_trans, new_trans_pulse, single, write_active, read_det,
               input read_active);

endinterface

/* src/axi_resp_if.sv */
interface axi_resp_if;

  // Write response channel.
  logic                       bvalid;
  logic                       bready;
  ahbl_bridge_pkg::axi_resp_t bresp;

  // Read data channel.
  logic                       rvalid;
  logic                       rready;
  logic                       rlast;
  ahbl_bridge_pkg::axi_resp_t rresp;
  ahbl_bridge_pkg::data_t     rdata;

  // Write data channel status seen from the AXI side.
  logic                       wready;
  logic                       wlast;

  // Full view for the HREADY and response logic.
  modport sink (input bvalid, bready, bresp, rvalid, rready, rlast, rresp, rdata,
                input wready, wlast);

  // Completion view for the detection and beat tracking logic.
  modport trk (input bvalid, bready, rvalid, rready, rlast, wlast);

endinterface

/* src/ahbl_bridge_pkg.sv */
package ahbl_bridge_pkg;

`include "ahbl_bridge_settings.svh"

  // AHB transfer type, as driven on HTRANS.
  typedef enum logic [1:0]
  {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // AHB burst type, as driven on HBURST.
  typedef enum logic [2:0]
  {
    SINGLE = 3'b000,
    INCR   = 3'b001,
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_t;

  typedef logic [`AHBL_BURST_CNT_WIDTH-1:0] burst_cnt_t;

  // AXI response code. Bit 1 flags SLVERR or DECERR.
  typedef logic [1:0] axi_resp_t;

  typedef logic [`AHBL_DATA_WIDTH-1:0] data_t;

endpackage

/* src/ahbl_bridge_settings.svh */
`ifndef AHBL_BRIDGE_SETTINGS_SVH
`define AHBL_BRIDGE_SETTINGS_SVH

// Width of the AHB read data bus and of the AXI read data channel.
// Both sides of the bridge move whole words, so one width serves both.
`define AHBL_DATA_WIDTH 32

// Width of the fixed-burst beat counter.
// The longest fixed burst is 16 beats, so the counter loads at most 15.
`define AHBL_BURST_CNT_WIDTH 4

`endif
